// File: compile.f
logic/fcore_pkg.sv
logic/program_memory.sv
logic/channel_sequencer.sv
logic/issue_stage.sv
logic/control_fsm.sv
logic/fcore_sequencer_top.sv
bench/fcore_sequencer_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= fcore_sequencer_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= sim passed
FAIL_TEXT ?= sim failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fcore_sequencer_tb.sv
// Sequencer core testbench
`timescale 1ns/1ps
`default_nettype none

module fcore_sequencer_tb;
    import fcore_pkg::*;

    localparam int PROGRAM_A_SIZE = 9;
    localparam int PROGRAM_B_SIZE = 5;
    localparam int FIRST_CHANNELS = 3;
    localparam int SECOND_CHANNELS = 2;
    localparam int FAULT_CHANNELS = 2;
    localparam int TIMEOUT_CYCLES = (PROGRAM_A_SIZE * (FIRST_CHANNELS + SECOND_CHANNELS)
                                     + PROGRAM_B_SIZE * FAULT_CHANNELS) * 20 + 400;

    logic clock;
    logic reset;
    prog_write_t prog_write;
    logic prog_write_valid;
    logic prog_write_ready;
    issue_t issue;
    logic issue_valid;
    logic issue_ready;
    logic run;
    pc_t program_size;
    channel_t n_channels;
    logic efi_start;
    channel_t efi_channel;
    logic efi_done;
    word_t load_data;
    logic done;
    logic fault;
    logic busy;

    integer seed = 32'h4c75;
    // Operands 32'hdead_beef and 32'hcafe_f00e carry STOP and EFI codes in their low bits
    word_t program_a [PROGRAM_A_SIZE] = '{32'h0000_0021, 32'h0000_008c, 32'hdead_beef,
        32'h0000_1043, 32'h0000_000e, 32'h0000_02cc, 32'h1234_5678, 32'h0000_0005,
        32'h0000_000f};
    word_t program_b [PROGRAM_B_SIZE] = '{32'h0000_0061, 32'h0000_000e, 32'h0000_00ec,
        32'hcafe_f00e, 32'h0000_0107};
    word_t program_words [$];
    issue_t expected_items [$];
    word_t expected_load [$];
    bit load_known [$];
    int expected_efi [$];
    int done_count;
    bit holding;
    issue_t held_item;

    fcore_sequencer_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        stop_run($sformatf("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want));
    endtask

    task automatic write_program();
        for (int address = 0; address < program_words.size(); address++) begin
            prog_write.address = pc_t'(address);
            prog_write.data = program_words[address];
            prog_write_valid = 1'b1;
            do @(posedge clock); while (!prog_write_ready);
            @(negedge clock);
        end
        prog_write_valid = 1'b0;
    endtask

    // Reference model that walks the program the way the core should
    task automatic build_expected(input int channels, input int size, output bit ends_in_fault);
        int pc;
        bit stopped;
        bit known;
        word_t constant;
        word_t instr;
        issue_t item;
        pc = 0;
        stopped = 1'b0;
        known = 1'b0;
        constant = '0;
        while (pc < size && !stopped) begin
            instr = program_words[pc];
            if (instr[4:0] == OP_STOP) begin
                stopped = 1'b1;
            end else if (instr[4:0] == OP_EFI) begin
                for (int ch = 0; ch < channels; ch++) expected_efi.push_back(ch);
                pc = pc + 1;
            end else begin
                if (instr[4:0] == OP_LDC) begin
                    known = 1'b1;
                    constant = program_words[pc + 1];
                end
                for (int ch = 0; ch < channels; ch++) begin
                    item.instr = instr;
                    item.channel = channel_t'(ch);
                    item.pc = pc_t'(pc);
                    expected_items.push_back(item);
                    expected_load.push_back(constant);
                    load_known.push_back(known);
                end
                pc = pc + ((instr[4:0] == OP_LDC) ? 2 : 1);
            end
        end
        ends_in_fault = !stopped;
    endtask

    task automatic execute_run(input int channels, input int size);
        bit ends_in_fault;
        int done_base;
        build_expected(channels, size, ends_in_fault);
        done_base = done_count;
        program_size = pc_t'(size);
        n_channels = channel_t'(channels);
        run = 1'b1;
        @(negedge clock);
        run = 1'b0;
        if (ends_in_fault) begin
            do @(negedge clock); while (!fault || expected_items.size() != 0);
            repeat (10) begin
                @(negedge clock);
                assert (fault && busy) else stop_run("fault dropped before reset");
            end
            assert (done_count == done_base && expected_efi.size() == 0)
                else stop_run("done or an EFI call seen in a run that faults");
            reset = 1'b1;
            repeat (4) @(negedge clock);
            reset = 1'b0;
            assert (!fault && prog_write_ready) else stop_run("core not idle after reset");
        end else begin
            do @(negedge clock); while (!done && !fault);
            assert (!fault) else stop_run("fault raised in a run that ends with STOP");
            repeat (3) @(negedge clock);
            assert (done_count - done_base == 1)
                else report_mismatch("done pulses", 64'(done_count - done_base), 64'd1);
            assert (!busy && prog_write_ready) else stop_run("core not idle after done");
            assert (expected_efi.size() == 0) else stop_run("fewer EFI calls than expected");
        end
    endtask

    // Ready is high about three cycles in four
    initial begin : ready_driver
        issue_ready = 1'b0;
        forever begin
            @(negedge clock);
            issue_ready = ($random(seed) & 3) != 0;
        end
    end

    // External function unit with a random latency
    initial begin : efi_unit
        int delay;
        efi_done = 1'b0;
        forever begin
            @(posedge clock);
            if (efi_start) begin
                delay = $unsigned($random(seed)) % 5;
                repeat (delay) @(posedge clock);
                @(negedge clock);
                efi_done = 1'b1;
                @(negedge clock);
                efi_done = 1'b0;
            end
        end
    end

    always @(posedge clock) begin : monitor
        issue_t want;
        word_t want_load;
        bit check_load;
        int want_channel;
        if (!reset) begin
            if (holding) begin
                assert (issue_valid) else stop_run("issue_valid dropped before acceptance");
                assert (issue == held_item)
                    else report_mismatch("held issue", 64'(issue), 64'(held_item));
            end
            if (issue_valid && issue_ready) begin
                assert (expected_items.size() > 0) else stop_run("more items than expected");
                want = expected_items.pop_front();
                want_load = expected_load.pop_front();
                check_load = load_known.pop_front();
                assert (issue.pc == want.pc)
                    else report_mismatch("issue.pc", 64'(issue.pc), 64'(want.pc));
                assert (issue.channel == want.channel)
                    else report_mismatch("issue.channel", 64'(issue.channel), 64'(want.channel));
                assert (issue.instr == want.instr)
                    else report_mismatch("issue.instr", 64'(issue.instr), 64'(want.instr));
                assert (!check_load || load_data == want_load)
                    else report_mismatch("load_data", 64'(load_data), 64'(want_load));
            end
            if (efi_start) begin
                assert (expected_efi.size() > 0) else stop_run("efi_start with no call expected");
                want_channel = expected_efi.pop_front();
                assert (int'(efi_channel) == want_channel)
                    else report_mismatch("efi_channel", 64'(efi_channel), 64'(want_channel));
            end
            if (done) begin
                assert (expected_items.size() == 0 && !issue_valid)
                    else stop_run("done pulsed before every item was accepted");
                done_count++;
            end
            holding = issue_valid && !issue_ready;
            held_item = issue;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        stop_run($sformatf("Timeout after %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin : stimulus
        reset = 1'b1;
        prog_write = '0;
        prog_write_valid = 1'b0;
        run = 1'b0;
        program_size = '0;
        n_channels = 8'd1;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        foreach (program_a[i]) program_words.push_back(program_a[i]);
        write_program();
        execute_run(FIRST_CHANNELS, PROGRAM_A_SIZE);
        // Same program again with fewer channels
        execute_run(SECOND_CHANNELS, PROGRAM_A_SIZE);
        // Without a STOP the program counter runs into program_size
        program_words.delete();
        foreach (program_b[i]) program_words.push_back(program_b[i]);
        write_program();
        execute_run(FAULT_CHANNELS, PROGRAM_B_SIZE);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/fcore_sequencer_top.sv
// Multichannel sequencer core
`timescale 1ns/1ps
`default_nettype none

module fcore_sequencer_top #(
    parameter int PROGRAM_DEPTH = 1024
) (
    input  logic                   clock,
    input  logic                   reset,
    input  fcore_pkg::prog_write_t prog_write,
    input  logic                   prog_write_valid,
    output logic                   prog_write_ready,
    output fcore_pkg::issue_t      issue,
    output logic                   issue_valid,
    input  logic                   issue_ready,
    input  logic                   run,
    input  fcore_pkg::pc_t         program_size,
    input  fcore_pkg::channel_t    n_channels,
    output logic                   efi_start,
    output fcore_pkg::channel_t    efi_channel,
    input  logic                   efi_done,
    output fcore_pkg::word_t       load_data,
    output logic                   done,
    output logic                   fault,
    output logic                   busy
);
    import fcore_pkg::*;

    word_t word_first;
    word_t word_second;
    opcode_t opcode;
    pc_t pc;
    channel_t channel;
    logic write_enable_allowed;
    logic write_enable;
    logic restart;
    logic step;
    logic issue_fire;
    logic last_channel;
    logic overrun;
    logic can_accept;
    logic empty;

    assign prog_write_ready = write_enable_allowed;
    assign write_enable = prog_write_valid && prog_write_ready;
    assign opcode = opcode_of(word_first);
    assign efi_channel = channel;

    program_memory #(.PROGRAM_DEPTH(PROGRAM_DEPTH)) memory (
        .clock(clock), .write(prog_write), .write_enable(write_enable),
        .read_address(pc), .word_first(word_first), .word_second(word_second)
    );

    channel_sequencer #(.PROGRAM_DEPTH(PROGRAM_DEPTH)) sequencer (
        .clock(clock), .reset(reset), .restart(restart), .step(step),
        .opcode(opcode), .n_channels(n_channels), .program_size(program_size),
        .pc(pc), .channel(channel), .last_channel(last_channel), .overrun(overrun)
    );

    issue_stage stage (
        .clock(clock), .reset(reset), .fire(issue_fire),
        .instr(word_first), .operand(word_second), .channel(channel), .pc(pc),
        .issue(issue), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .can_accept(can_accept), .empty(empty), .load_data(load_data)
    );

    control_fsm control (
        .clock(clock), .reset(reset), .run(run), .opcode(opcode),
        .last_channel(last_channel), .overrun(overrun),
        .can_accept(can_accept), .empty(empty), .efi_done(efi_done),
        .restart(restart), .step(step), .issue_fire(issue_fire),
        .efi_start(efi_start), .write_enable_allowed(write_enable_allowed),
        .done(done), .fault(fault), .busy(busy)
    );

endmodule

`default_nettype wire

// File: logic/control_fsm.sv
// Sequencer control FSM
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
    input  logic               clock,
    input  logic               reset,
    input  logic               run,
    input  fcore_pkg::opcode_t opcode,
    input  logic               last_channel,
    input  logic               overrun,
    input  logic               can_accept,
    input  logic               empty,
    input  logic               efi_done,
    output logic               restart,
    output logic               step,
    output logic               issue_fire,
    output logic               efi_start,
    output logic               write_enable_allowed,
    output logic               done,
    output logic               fault,
    output logic               busy
);
    import fcore_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_LOAD,
        RUN,
        EFI_CALL,
        DRAIN,
        FAULT
    } state_t;

    state_t state;
    state_t next_state;
    logic start_call;
    logic finish;

    always_comb begin
        next_state = state;
        restart = 1'b0;
        step = 1'b0;
        issue_fire = 1'b0;
        start_call = 1'b0;
        finish = 1'b0;
        case (state)
            IDLE: begin
                if (run) begin
                    restart = 1'b1;
                    next_state = WAIT_LOAD;
                end
            end
            // Gives the program store one cycle to present the new pc
            WAIT_LOAD: next_state = RUN;
            RUN: begin
                if (overrun) begin
                    next_state = FAULT;
                end else if (opcode == OP_STOP) begin
                    next_state = DRAIN;
                end else if (opcode == OP_EFI) begin
                    start_call = 1'b1;
                    next_state = EFI_CALL;
                end else if (can_accept) begin
                    issue_fire = 1'b1;
                    step = 1'b1;
                    if (last_channel) begin
                        next_state = WAIT_LOAD;
                    end
                end
            end
            EFI_CALL: begin
                // The unit answers no earlier than the cycle after its start pulse
                if (efi_done && !efi_start) begin
                    step = 1'b1;
                    next_state = last_channel ? WAIT_LOAD : RUN;
                end
            end
            DRAIN: begin
                if (empty) begin
                    finish = 1'b1;
                    next_state = IDLE;
                end
            end
            FAULT: next_state = FAULT;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            efi_start <= 1'b0;
            done <= 1'b0;
        end else begin
            state <= next_state;
            efi_start <= start_call;
            done <= finish;
        end
    end

    assign write_enable_allowed = (state == IDLE);
    assign busy = (state != IDLE);
    assign fault = (state == FAULT);

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
// Issue stream output register
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                clock,
    input  logic                reset,
    input  logic                fire,
    input  fcore_pkg::word_t    instr,
    input  fcore_pkg::word_t    operand,
    input  fcore_pkg::channel_t channel,
    input  fcore_pkg::pc_t      pc,
    output fcore_pkg::issue_t   issue,
    output logic                issue_valid,
    input  logic                issue_ready,
    output logic                can_accept,
    output logic                empty,
    output fcore_pkg::word_t    load_data
);
    import fcore_pkg::*;

    // A new item may enter while the held one leaves in the same cycle
    assign can_accept = !issue_valid || issue_ready;
    assign empty = !issue_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (fire) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            issue.instr <= instr;
            issue.channel <= channel;
            issue.pc <= pc;
            // The constant stays published until the next LDC
            if (opcode_of(instr) == OP_LDC) begin
                load_data <= operand;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/channel_sequencer.sv
// Program and channel counters
`timescale 1ns/1ps
`default_nettype none

module channel_sequencer #(
    parameter int PROGRAM_DEPTH = 1024
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                restart,
    input  logic                step,
    input  fcore_pkg::opcode_t  opcode,
    input  fcore_pkg::channel_t n_channels,
    input  fcore_pkg::pc_t      program_size,
    output fcore_pkg::pc_t      pc,
    output fcore_pkg::channel_t channel,
    output logic                last_channel,
    output logic                overrun
);
    import fcore_pkg::*;

    localparam logic [PC_WIDTH:0] LAST_ADDRESS = (PC_WIDTH + 1)'(PROGRAM_DEPTH - 1);

    logic [PC_WIDTH:0] next_pc;
    logic past_end;

    assign last_channel = (channel == channel_t'(n_channels - 1'b1));

    // One extra bit catches a step past the top of the program store
    assign next_pc = {1'b0, pc} + ((opcode == OP_LDC) ? (PC_WIDTH + 1)'(2)
                                                      : (PC_WIDTH + 1)'(1));

    assign overrun = past_end || (pc >= program_size);

    always_ff @(posedge clock) begin
        if (reset || restart) begin
            pc <= '0;
            channel <= '0;
            past_end <= 1'b0;
        end else if (step) begin
            if (last_channel) begin
                channel <= '0;
                if (next_pc > LAST_ADDRESS) begin
                    pc <= pc_t'(LAST_ADDRESS);
                    past_end <= 1'b1;
                end else begin
                    pc <= pc_t'(next_pc);
                end
            end else begin
                channel <= channel + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/program_memory.sv
// Program store
`timescale 1ns/1ps
`default_nettype none

module program_memory #(
    parameter int PROGRAM_DEPTH = 1024
) (
    input  logic                   clock,
    input  fcore_pkg::prog_write_t write,
    input  logic                   write_enable,
    input  fcore_pkg::pc_t         read_address,
    output fcore_pkg::word_t       word_first,
    output fcore_pkg::word_t       word_second
);
    import fcore_pkg::*;

    word_t memory [PROGRAM_DEPTH];
    pc_t second_address;

    // The operand of a two-word instruction may sit at the top of the store
    assign second_address = (read_address == pc_t'(PROGRAM_DEPTH - 1))
                            ? '0 : read_address + 1'b1;

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write.address] <= write.data;
        end
    end

    // Both words are registered together so an operand arrives with its opcode
    always_ff @(posedge clock) begin
        word_first <= memory[read_address];
        word_second <= memory[second_address];
    end

endmodule

`default_nettype wire

// File: logic/fcore_pkg.sv
// Sequencer core shared types
`default_nettype none

package fcore_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int OPCODE_WIDTH = 5;
    localparam int PC_WIDTH = 10;
    localparam int CHANNEL_WIDTH = 8;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [PC_WIDTH-1:0] pc_t;
    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

    // Only the codes that change sequencing are named
    // Every other value is an ordinary instruction
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_LDC  = 5'd12,
        OP_EFI  = 5'd14,
        OP_STOP = 5'd15
    } opcode_t;

    typedef struct packed {
        word_t instr;
        channel_t channel;
        pc_t pc;
    } issue_t;

    typedef struct packed {
        pc_t address;
        word_t data;
    } prog_write_t;

    // The opcode sits in the low bits of the first word
    function automatic opcode_t opcode_of(word_t word);
        return opcode_t'(word[OPCODE_WIDTH-1:0]);
    endfunction

endpackage

`default_nettype wire
